//--- verilog/i3c_target_pkg.sv
// Bus widths, byte and address types, RX descriptor layout, broadcast address
`default_nettype none

package i3c_target_pkg;

  localparam int unsigned ByteWidth = 8;
  localparam int unsigned AddrWidth = 7;
  localparam int unsigned DescWidth = 32;

  typedef logic [ByteWidth-1:0] byte_t;
  typedef logic [AddrWidth-1:0] addr_t;

  // One descriptor per private write
  typedef struct packed {
    logic                 parity_err;
    logic                 overflow;
    // Bits left over between the flags and the count
    logic [DescWidth-19:0] reserved;
    logic [15:0]          byte_count;
  } rx_desc_t;

  // Broadcast address, refused since CCCs are not handled
  localparam addr_t BroadcastAddr = 7'h7E;

endpackage

`default_nettype wire

//--- verilog/bus_event_if.sv
// Synchronized SCL edges, bus condition pulses and SDA level
`timescale 1ns/1ps
`default_nettype none

interface bus_event_if;

  logic scl_posedge;
  logic scl_negedge;
  logic start;
  logic rstart;
  logic stop;
  logic sda;

  modport monitor (output scl_posedge, scl_negedge, start, rstart, stop, sda);

  modport consumer (input scl_posedge, scl_negedge, start, rstart, stop, sda);

endinterface

`default_nettype wire

//--- verilog/rx_flow_if.sv
// Four-phase request/ack handshake for bit and byte reception
`timescale 1ns/1ps
`default_nettype none

interface rx_flow_if
  import i3c_target_pkg::*;
();

  logic  req_byte;
  logic  req_bit;
  logic  ack;
  byte_t data;

  modport ctrl (output req_byte, req_bit, input ack, data);

  modport flow (input req_byte, req_bit, output ack, data);

endinterface

`default_nettype wire

//--- verilog/rx_byte_if.sv
// Received data bytes and end-of-transfer toward the descriptor builder
`timescale 1ns/1ps
`default_nettype none

interface rx_byte_if
  import i3c_target_pkg::*;
();

  logic  valid;
  byte_t data;
  logic  last;
  logic  parity_err;
  logic  ready;

  modport source (output valid, data, last, parity_err, input ready);

  modport sink (input valid, data, last, parity_err, output ready);

endinterface

`default_nettype wire

//--- verilog/bus_monitor.sv
// Bus monitor with SCL/SDA synchronizers, edge pulses and START/Sr/STOP detection
`timescale 1ns/1ps
`default_nettype none

module bus_monitor #(
  parameter int unsigned SyncStages = 2
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         scl_i,
  input  logic         sda_i,
  bus_event_if.monitor ev,
  output logic         start_o,
  output logic         rstart_o,
  output logic         stop_o
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_s;
  logic                  sda_s;
  logic                  scl_q;
  logic                  sda_q;
  logic                  in_xfer_q;
  logic                  start_det;
  logic                  stop_det;

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];

  // SDA moves while SCL stays high
  assign start_det = scl_s & scl_q & sda_q & ~sda_s;
  assign stop_det  = scl_s & scl_q & ~sda_q & sda_s;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q     <= '1;
      sda_sync_q     <= '1;
      scl_q          <= 1'b1;
      sda_q          <= 1'b1;
      in_xfer_q      <= 1'b0;
      ev.scl_posedge <= 1'b0;
      ev.scl_negedge <= 1'b0;
      ev.start       <= 1'b0;
      ev.rstart      <= 1'b0;
      ev.stop        <= 1'b0;
      ev.sda         <= 1'b1;
    end else begin
      scl_sync_q     <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q     <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_q          <= scl_s;
      sda_q          <= sda_s;
      ev.scl_posedge <= scl_s & ~scl_q;
      ev.scl_negedge <= ~scl_s & scl_q;
      // Repeated START when no STOP since the last START
      ev.start       <= start_det & ~in_xfer_q;
      ev.rstart      <= start_det & in_xfer_q;
      ev.stop        <= stop_det;
      ev.sda         <= sda_s;
      if (start_det) begin
        in_xfer_q <= 1'b1;
      end else if (stop_det) begin
        in_xfer_q <= 1'b0;
      end
    end
  end

  assign start_o  = ev.start;
  assign rstart_o = ev.rstart;
  assign stop_o   = ev.stop;

  // SCL and SDA never move in the same sample
  a_no_joint_change: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((scl_s != scl_q) && (sda_s != sda_q)));

endmodule

`default_nettype wire

//--- verilog/bus_rx_flow.sv
// Bit and byte receiver sampling SDA on SCL rising edges under a four-phase handshake
`timescale 1ns/1ps
`default_nettype none

module bus_rx_flow
  import i3c_target_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  bus_event_if.consumer ev,
  rx_flow_if.flow       rx
);

  logic       req;
  logic [3:0] bit_target;
  logic [3:0] bit_cnt_q;
  byte_t      shift_q;

  assign req        = rx.req_byte | rx.req_bit;
  assign bit_target = rx.req_byte ? 4'(ByteWidth) : 4'd1;
  assign rx.data    = shift_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
      rx.ack    <= 1'b0;
    end else if (ev.start || ev.rstart || ev.stop) begin
      bit_cnt_q <= '0;
      rx.ack    <= 1'b0;
    end else if (rx.ack) begin
      // Wait for the request to drop
      if (!req) begin
        rx.ack <= 1'b0;
      end
    end else if (req && ev.scl_posedge) begin
      if (bit_cnt_q + 4'd1 == bit_target) begin
        bit_cnt_q <= '0;
        rx.ack    <= 1'b1;
      end else begin
        bit_cnt_q <= bit_cnt_q + 4'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && !rx.ack && ev.scl_posedge) begin
      shift_q <= {shift_q[ByteWidth-2:0], ev.sda};
    end
  end

  a_one_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rx.req_byte && rx.req_bit));

endmodule

`default_nettype wire

//--- verilog/target_fsm.sv
// Target control FSM for address match, ACK/NACK, write data and T-bit check
`timescale 1ns/1ps
`default_nettype none

module target_fsm
  import i3c_target_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  bus_event_if.consumer ev,
  rx_flow_if.ctrl       rx,
  rx_byte_if.source     out,
  input  addr_t         target_sta_addr_i,
  input  logic          target_sta_addr_valid_i,
  input  addr_t         target_dyn_addr_i,
  input  logic          target_dyn_addr_valid_i,
  output logic          sda_o,
  output byte_t         addr_o,
  output logic          addr_valid_o
);

  typedef enum logic [2:0] {
    Idle,
    Addr,
    AckBit,
    Data,
    TBit,
    Ignore
  } state_e;

  state_e state_q;
  logic   ack_low_q;
  logic   match_q;
  logic   xfer_open_q;
  byte_t  data_q;
  logic   start_any;
  logic   bus_cond;
  addr_t  rx_addr;
  logic   addr_hit;
  logic   t_ok;

  assign start_any = ev.start | ev.rstart;
  assign bus_cond  = start_any | ev.stop;
  assign rx_addr   = rx.data[ByteWidth-1:1];

  // Dynamic address takes over from the static one once assigned
  assign addr_hit = !rx.data[0] && (rx_addr != BroadcastAddr) &&
                    (target_dyn_addr_valid_i ? (rx_addr == target_dyn_addr_i) :
                     (target_sta_addr_valid_i && (rx_addr == target_sta_addr_i)));

  // Odd parity over data and T-bit
  assign t_ok = ^{data_q, rx.data[0]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= Idle;
      rx.req_byte    <= 1'b0;
      rx.req_bit     <= 1'b0;
      sda_o          <= 1'b1;
      ack_low_q      <= 1'b0;
      match_q        <= 1'b0;
      xfer_open_q    <= 1'b0;
      addr_valid_o   <= 1'b0;
      out.valid      <= 1'b0;
      out.last       <= 1'b0;
      out.parity_err <= 1'b0;
    end else begin
      addr_valid_o <= 1'b0;
      out.valid    <= 1'b0;
      out.last     <= 1'b0;
      if (bus_cond) begin
        rx.req_byte <= 1'b0;
        rx.req_bit  <= 1'b0;
        sda_o       <= 1'b1;
        ack_low_q   <= 1'b0;
        out.last    <= xfer_open_q;
        xfer_open_q <= 1'b0;
        state_q     <= start_any ? Addr : Idle;
      end else begin
        case (state_q)
          Addr: begin
            if (rx.req_byte && rx.ack) begin
              rx.req_byte  <= 1'b0;
              addr_valid_o <= 1'b1;
              match_q      <= addr_hit;
              state_q      <= AckBit;
            end else if (!rx.ack) begin
              rx.req_byte <= 1'b1;
            end
          end
          AckBit: begin
            // First falling edge opens the ACK bit, the second closes it
            if (ev.scl_negedge) begin
              if (!ack_low_q) begin
                ack_low_q <= 1'b1;
                sda_o     <= ~match_q;
              end else begin
                ack_low_q   <= 1'b0;
                sda_o       <= 1'b1;
                xfer_open_q <= match_q;
                state_q     <= match_q ? Data : Ignore;
              end
            end
          end
          Data: begin
            if (rx.req_byte && rx.ack) begin
              rx.req_byte <= 1'b0;
              state_q     <= TBit;
            end else if (!rx.ack) begin
              rx.req_byte <= 1'b1;
            end
          end
          TBit: begin
            if (rx.req_bit && rx.ack) begin
              rx.req_bit     <= 1'b0;
              out.valid      <= 1'b1;
              out.parity_err <= ~t_ok;
              state_q        <= Data;
            end else if (!rx.ack) begin
              rx.req_bit <= 1'b1;
            end
          end
          Idle, Ignore: ;
          default: state_q <= Idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == Addr && rx.req_byte && rx.ack && !bus_cond) begin
      addr_o <= rx.data;
    end
    if (state_q == Data && rx.req_byte && rx.ack) begin
      data_q <= rx.data;
    end
    if (state_q == TBit && rx.req_bit && rx.ack) begin
      out.data <= data_q;
    end
  end

  // Bytes are never offered while the builder writes a descriptor
  a_byte_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out.valid |-> out.ready);

endmodule

`default_nettype wire

//--- verilog/descriptor_rx.sv
// RX descriptor builder forwarding bytes to the RX queue and writing one descriptor per write
`timescale 1ns/1ps
`default_nettype none

module descriptor_rx
  import i3c_target_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  rx_byte_if.sink  in,
  input  logic     rx_queue_full_i,
  output logic     rx_queue_wvalid_o,
  output byte_t    rx_queue_wdata_o,
  output logic     rx_desc_queue_wvalid_o,
  output rx_desc_t rx_desc_queue_wdata_o
);

  logic [15:0] byte_cnt_q;
  logic        parity_acc_q;
  logic        overflow_acc_q;

  assign in.ready = ~rx_desc_queue_wvalid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
      byte_cnt_q             <= '0;
      parity_acc_q           <= 1'b0;
      overflow_acc_q         <= 1'b0;
    end else begin
      // A full queue drops the byte but it still counts
      rx_queue_wvalid_o      <= in.valid & ~rx_queue_full_i;
      rx_desc_queue_wvalid_o <= in.last;
      if (in.last) begin
        byte_cnt_q     <= '0;
        parity_acc_q   <= 1'b0;
        overflow_acc_q <= 1'b0;
      end else if (in.valid) begin
        byte_cnt_q     <= byte_cnt_q + 16'd1;
        parity_acc_q   <= parity_acc_q | in.parity_err;
        overflow_acc_q <= overflow_acc_q | rx_queue_full_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in.valid) begin
      rx_queue_wdata_o <= in.data;
    end
    if (in.last) begin
      rx_desc_queue_wdata_o.parity_err <= parity_acc_q;
      rx_desc_queue_wdata_o.overflow   <= overflow_acc_q;
      rx_desc_queue_wdata_o.reserved   <= '0;
      rx_desc_queue_wdata_o.byte_count <= byte_cnt_q;
    end
  end

  a_no_write_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rx_queue_wvalid_o && rx_desc_queue_wvalid_o));

endmodule

`default_nettype wire

//--- verilog/i3c_target_rx.sv
// Receive-only I3C target top level for SDR private writes
`timescale 1ns/1ps
`default_nettype none

module i3c_target_rx
  import i3c_target_pkg::*;
#(
  parameter int unsigned SyncStages = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     ctrl_scl_i,
  input  logic     ctrl_sda_i,
  output logic     ctrl_sda_o,
  input  addr_t    target_sta_addr_i,
  input  logic     target_sta_addr_valid_i,
  input  addr_t    target_dyn_addr_i,
  input  logic     target_dyn_addr_valid_i,
  input  logic     rx_queue_full_i,
  output logic     rx_queue_wvalid_o,
  output byte_t    rx_queue_wdata_o,
  output logic     rx_desc_queue_wvalid_o,
  output rx_desc_t rx_desc_queue_wdata_o,
  output logic     bus_start_o,
  output logic     bus_rstart_o,
  output logic     bus_stop_o,
  output byte_t    bus_addr_o,
  output logic     bus_addr_valid_o
);

  bus_event_if bus_ev ();
  rx_flow_if   rx_flow ();
  rx_byte_if   rx_byte ();

  bus_monitor #(
    .SyncStages(SyncStages)
  ) u_bus_monitor (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .scl_i   (ctrl_scl_i),
    .sda_i   (ctrl_sda_i),
    .ev      (bus_ev),
    .start_o (bus_start_o),
    .rstart_o(bus_rstart_o),
    .stop_o  (bus_stop_o)
  );

  bus_rx_flow u_bus_rx_flow (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .ev    (bus_ev),
    .rx    (rx_flow)
  );

  target_fsm u_target_fsm (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .ev                     (bus_ev),
    .rx                     (rx_flow),
    .out                    (rx_byte),
    .target_sta_addr_i      (target_sta_addr_i),
    .target_sta_addr_valid_i(target_sta_addr_valid_i),
    .target_dyn_addr_i      (target_dyn_addr_i),
    .target_dyn_addr_valid_i(target_dyn_addr_valid_i),
    .sda_o                  (ctrl_sda_o),
    .addr_o                 (bus_addr_o),
    .addr_valid_o           (bus_addr_valid_o)
  );

  descriptor_rx u_descriptor_rx (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .in                    (rx_byte),
    .rx_queue_full_i       (rx_queue_full_i),
    .rx_queue_wvalid_o     (rx_queue_wvalid_o),
    .rx_queue_wdata_o      (rx_queue_wdata_o),
    .rx_desc_queue_wvalid_o(rx_desc_queue_wvalid_o),
    .rx_desc_queue_wdata_o (rx_desc_queue_wdata_o)
  );

endmodule

`default_nettype wire

//--- testbench/i3c_bus_tasks.svh
// Bus controller tasks for START, repeated START, STOP, bits, bytes, ACK and T-bits
`ifndef I3C_BUS_TASKS_SVH
`define I3C_BUS_TASKS_SVH

// Ends 2 ns after a rising clock edge
task automatic wait_cycles(input int n);
  repeat (n) @(posedge clk_i);
  #2;
endtask

task automatic send_start();
  ctrl_sda_i = 1'b0;
  wait_cycles(PhaseCycles);
  ctrl_scl_i = 1'b0;
endtask

// SDA changes in the middle of the low phase
task automatic send_bit(input logic b);
  wait_cycles(PhaseCycles / 2);
  ctrl_sda_i = b;
  wait_cycles(PhaseCycles / 2);
  ctrl_scl_i = 1'b1;
  wait_cycles(PhaseCycles);
  ctrl_scl_i = 1'b0;
endtask

// MSB first
task automatic send_byte(input byte_t b);
  int i;
  for (i = ByteWidth - 1; i >= 0; i--) begin
    send_bit(b[i]);
  end
endtask

// SDA released, target pulls it low to ACK
task automatic read_ack(output logic acked);
  wait_cycles(PhaseCycles / 2);
  ctrl_sda_i = 1'b1;
  wait_cycles(PhaseCycles / 2);
  ctrl_scl_i = 1'b1;
  wait_cycles(PhaseCycles / 2);
  acked = ~ctrl_sda_o;
  wait_cycles(PhaseCycles / 2);
  ctrl_scl_i = 1'b0;
endtask

// Odd-parity T-bit, inverted when corrupt is set
task automatic send_data_byte(input byte_t b, input logic corrupt);
  send_byte(b);
  send_bit(~(^b) ^ corrupt);
endtask

task automatic send_rstart();
  wait_cycles(PhaseCycles / 2);
  ctrl_sda_i = 1'b1;
  wait_cycles(PhaseCycles / 2);
  ctrl_scl_i = 1'b1;
  wait_cycles(PhaseCycles);
  ctrl_sda_i = 1'b0;
  wait_cycles(PhaseCycles);
  ctrl_scl_i = 1'b0;
endtask

task automatic send_stop();
  wait_cycles(PhaseCycles / 2);
  ctrl_sda_i = 1'b0;
  wait_cycles(PhaseCycles / 2);
  ctrl_scl_i = 1'b1;
  wait_cycles(PhaseCycles);
  ctrl_sda_i = 1'b1;
  wait_cycles(PhaseCycles);
endtask

`endif

//--- testbench/tb_i3c_target_rx.sv
// Testbench for the I3C receive target with a transaction table, bus monitors and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_i3c_target_rx
  import i3c_target_pkg::*;
();

  localparam int NumRows = 8;
  localparam int PhaseCycles = 8;
  localparam addr_t StaAddr = 7'h2A;
  localparam addr_t DynAddr = 7'h31;

  logic     clk_i;
  logic     rst_ni;
  logic     ctrl_scl_i;
  logic     ctrl_sda_i;
  logic     ctrl_sda_o;
  addr_t    target_sta_addr_i;
  logic     target_sta_addr_valid_i;
  addr_t    target_dyn_addr_i;
  logic     target_dyn_addr_valid_i;
  logic     rx_queue_full_i;
  logic     rx_queue_wvalid_o;
  byte_t    rx_queue_wdata_o;
  logic     rx_desc_queue_wvalid_o;
  rx_desc_t rx_desc_queue_wdata_o;
  logic     bus_start_o;
  logic     bus_rstart_o;
  logic     bus_stop_o;
  byte_t    bus_addr_o;
  logic     bus_addr_valid_o;

  // Data byte i of a row sits at bits 8*i and zero bytes become random filler
  string       row_name   [NumRows];
  byte_t       row_addr   [NumRows];
  addr_t       row_sta    [NumRows];
  int          row_len    [NumRows];
  logic [31:0] row_data   [NumRows];
  logic [3:0]  row_bad_t  [NumRows];
  logic [3:0]  row_full   [NumRows];
  logic        row_rstart [NumRows];
  logic        row_dyn    [NumRows];
  logic        row_ack    [NumRows];

  byte_t    wdata_q[$];
  rx_desc_t desc_q[$];
  byte_t    addr_q[$];
  int       start_cnt = 0;
  int       rstart_cnt = 0;
  int       stop_cnt = 0;
  int       cycle_cnt = 0;
  int       cycle_limit = 1000;

  i3c_target_rx #(.SyncStages(2)) i_dut (.*);

  `include "i3c_bus_tasks.svh"

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    if (rx_queue_wvalid_o) wdata_q.push_back(rx_queue_wdata_o);
    if (rx_desc_queue_wvalid_o) desc_q.push_back(rx_desc_queue_wdata_o);
    if (bus_addr_valid_o) addr_q.push_back(bus_addr_o);
    if (bus_start_o) start_cnt++;
    if (bus_rstart_o) rstart_cnt++;
    if (bus_stop_o) stop_cnt++;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("TIMEOUT: test sequence still running after %0d cycles", cycle_cnt);
      $display("Something failed");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input string what, input int exp,
                             input int act);
    assert (exp == act) else begin
      $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", name, what, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic set_row(input int idx, input string name, input byte_t addr, input addr_t sta,
                         input int len, input logic [31:0] data, input logic [3:0] bad_t,
                         input logic [3:0] full, input logic rstart, input logic dyn,
                         input logic ack);
    row_name[idx]   = name;
    row_addr[idx]   = addr;
    row_sta[idx]    = sta;
    row_len[idx]    = len;
    row_data[idx]   = data;
    row_bad_t[idx]  = bad_t;
    row_full[idx]   = full;
    row_rstart[idx] = rstart;
    row_dyn[idx]    = dyn;
    row_ack[idx]    = ack;
  endtask

  initial begin
    int         seed;
    byte_t      bytes [4];
    logic       acked;
    logic [3:0] len_mask;
    rx_desc_t   desc;
    int         kept;
    int         exp_start;
    int         exp_rstart;
    int         exp_stop;
    logic       prev_rstart;
    seed = $urandom(38);
    set_row(0, "static_write", 8'h54, StaAddr, 3, 32'h0000_3CA5, 4'b0000, 4'b0000, 0, 0, 1);
    set_row(1, "parity_error", 8'h54, StaAddr, 4, 32'h8877_0F01, 4'b0100, 4'b0000, 0, 0, 1);
    set_row(2, "queue_full", 8'h54, StaAddr, 4, 32'h0000_0000, 4'b0000, 4'b0101, 0, 0, 1);
    set_row(3, "empty_write_rstart", 8'h54, StaAddr, 0, 32'h0, 4'b0000, 4'b0000, 1, 0, 1);
    set_row(4, "read_nack", 8'h55, StaAddr, 0, 32'h0, 4'b0000, 4'b0000, 1, 0, 0);
    // Static address set to 7'h7E so only the broadcast refusal can NACK it
    set_row(5, "broadcast_nack", 8'hFC, 7'h7E, 0, 32'h0, 4'b0000, 4'b0000, 0, 0, 0);
    set_row(6, "static_with_dyn_nack", 8'h54, StaAddr, 0, 32'h0, 4'b0000, 4'b0000, 1, 1, 0);
    set_row(7, "dynamic_write", 8'h62, StaAddr, 2, 32'h0000_F00D, 4'b0000, 4'b0000, 0, 1, 1);
    for (int r = 0; r < NumRows; r++) begin
      cycle_limit += (row_len[r] + 3) * 9 * 2 * PhaseCycles;
    end

    rst_ni                  = 1'b0;
    ctrl_scl_i              = 1'b1;
    ctrl_sda_i              = 1'b1;
    target_sta_addr_i       = StaAddr;
    target_sta_addr_valid_i = 1'b1;
    target_dyn_addr_i       = DynAddr;
    target_dyn_addr_valid_i = 1'b0;
    rx_queue_full_i         = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check_value("reset", "ctrl_sda_o", 1, ctrl_sda_o);
    check_value("reset", "rx_queue_wvalid_o", 0, rx_queue_wvalid_o);
    check_value("reset", "rx_desc_queue_wvalid_o", 0, rx_desc_queue_wvalid_o);
    wait_cycles(4);

    exp_start   = 0;
    exp_rstart  = 0;
    exp_stop    = 0;
    prev_rstart = 1'b0;
    for (int r = 0; r < NumRows; r++) begin
      target_sta_addr_i       = row_sta[r];
      target_dyn_addr_valid_i = row_dyn[r];
      for (int i = 0; i < 4; i++) begin
        bytes[i] = row_data[r][8*i +: 8];
        if (bytes[i] == 8'h00) bytes[i] = byte_t'($urandom);
      end
      if (!prev_rstart) begin
        send_start();
        exp_start++;
      end
      send_byte(row_addr[r]);
      read_ack(acked);
      check_value(row_name[r], "ack", row_ack[r], acked);
      for (int i = 0; i < row_len[r]; i++) begin
        rx_queue_full_i = row_full[r][i];
        send_data_byte(bytes[i], row_bad_t[r][i]);
      end
      rx_queue_full_i = 1'b0;
      if (row_rstart[r]) begin
        send_rstart();
        exp_rstart++;
      end else begin
        send_stop();
        exp_stop++;
      end
      prev_rstart = row_rstart[r];

      // Descriptor closes a matching write
      if (row_ack[r]) begin
        while (desc_q.size() == 0) wait_cycles(1);
      end
      check_value(row_name[r], "address pulses", 1, addr_q.size());
      check_value(row_name[r], "bus_addr_o", row_addr[r], addr_q.pop_front());
      if (row_ack[r]) begin
        len_mask = 4'((1 << row_len[r]) - 1);
        desc = desc_q.pop_front();
        check_value(row_name[r], "byte_count", row_len[r], desc.byte_count);
        check_value(row_name[r], "parity_err", |(row_bad_t[r] & len_mask), desc.parity_err);
        check_value(row_name[r], "overflow", |(row_full[r] & len_mask), desc.overflow);
        check_value(row_name[r], "reserved", 0, desc.reserved);
        kept = 0;
        for (int i = 0; i < row_len[r]; i++) begin
          if (!row_full[r][i]) kept++;
        end
        check_value(row_name[r], "queue writes", kept, wdata_q.size());
        for (int i = 0; i < row_len[r]; i++) begin
          if (!row_full[r][i]) begin
            check_value(row_name[r], "rx_queue_wdata_o", bytes[i], wdata_q.pop_front());
          end
        end
      end
      check_value(row_name[r], "extra queue writes", 0, wdata_q.size());
      check_value(row_name[r], "extra descriptors", 0, desc_q.size());
      check_value(row_name[r], "START pulses", exp_start, start_cnt);
      check_value(row_name[r], "repeated START pulses", exp_rstart, rstart_cnt);
      check_value(row_name[r], "STOP pulses", exp_stop, stop_cnt);
    end

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+testbench
verilog/i3c_target_pkg.sv
verilog/bus_event_if.sv
verilog/rx_flow_if.sv
verilog/rx_byte_if.sv
verilog/bus_monitor.sv
verilog/bus_rx_flow.sv
verilog/target_fsm.sv
verilog/descriptor_rx.sv
verilog/i3c_target_rx.sv
testbench/tb_i3c_target_rx.sv
